//--- design/lsu_pkg.sv
package lsu_pkg;

    // Data and address width
    localparam int XLEN = 32;

    // Address bit that selects the APB region
    localparam int BUS_REGION_BIT = 31;

    // Access size, same encoding as the fn3 field of loads and stores
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_size_t;

    // APB master transfer phases
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_SETUP,
        APB_ACCESS
    } apb_state_t;

    // Sub-unit that serves an access
    typedef enum logic {
        UNIT_SCRATCH,
        UNIT_BUS
    } ls_unit_t;

endpackage

//--- design/lsu_fifo.sv
`timescale 1ns/1ps

module lsu_fifo #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] data_in,
    output logic [WIDTH-1:0] data_out,
    output logic             valid,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // A full FIFO still takes a push when the head leaves in the same cycle
    assign do_pop  = pop & valid;
    assign do_push = push & (~full | do_pop);

    assign valid    = (count != '0);
    assign full     = (count == CNT_W'(DEPTH));
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push != do_pop) begin
                count <= do_push ? count + 1'b1 : count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end

endmodule

//--- design/ls_issue_stage.sv
`timescale 1ns/1ps

module ls_issue_stage #(
    parameter int IN_DEPTH  = 4,
    parameter int OUT_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_load,
    input  logic                       req_store,
    input  lsu_pkg::ls_size_t          req_fn3,
    input  logic [lsu_pkg::XLEN-1:0]   req_addr,
    input  logic [lsu_pkg::XLEN-1:0]   req_data,
    input  logic                       scratch_ready,
    input  logic                       bus_ready,
    input  logic                       load_valid,
    input  logic                       wb_accepted,
    input  logic                       attr_pending,
    output logic                       scratch_request,
    output logic                       bus_request,
    output logic [lsu_pkg::XLEN-1:0]   addr,
    output logic [lsu_pkg::XLEN/8-1:0] be,
    output logic [lsu_pkg::XLEN-1:0]   wdata,
    output logic                       rnw,
    output logic                       load_issued,
    output lsu_pkg::ls_size_t          load_fn3,
    output logic [1:0]                 load_offset,
    output logic                       misaligned
);

    localparam int XLEN  = lsu_pkg::XLEN;
    localparam int REQ_W = 5 + 2 * XLEN;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);

    logic [REQ_W-1:0]  head;
    logic              head_valid;
    logic              fifo_full;
    logic              head_load;
    logic              head_store;
    lsu_pkg::ls_size_t head_fn3;
    logic [XLEN-1:0]   head_data;
    logic              aligned;
    logic              issue;
    lsu_pkg::ls_unit_t cur_unit;
    lsu_pkg::ls_unit_t last_unit;
    logic              last_return;
    logic              unit_stall;
    logic [CNT_W-1:0]  inflight;
    logic [CNT_W-1:0]  sub_pending;

    lsu_fifo #(.WIDTH(REQ_W), .DEPTH(IN_DEPTH)) req_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (req_valid & ~fifo_full),
        .pop      (issue | misaligned),
        .data_in  ({req_load, req_store, req_fn3, req_addr, req_data}),
        .data_out (head),
        .valid    (head_valid),
        .full     (fifo_full)
    );

    assign req_ready  = ~fifo_full;
    assign head_load  = head[REQ_W-1];
    assign head_store = head[REQ_W-2];
    assign head_fn3   = lsu_pkg::ls_size_t'(head[REQ_W-3 -: 3]);
    assign addr       = head[2*XLEN-1 -: XLEN];
    assign head_data  = head[XLEN-1:0];

    always_comb begin
        case (head_fn3)
            lsu_pkg::LS_H, lsu_pkg::LS_HU: aligned = ~addr[0];
            lsu_pkg::LS_W:                 aligned = (addr[1:0] == 2'b00);
            default:                       aligned = 1'b1;
        endcase
    end

    // Byte lanes written by a store, loads leave them all clear
    always_comb begin
        be = '0;
        if (head_store) begin
            case (head_fn3[1:0])
                2'b10:   be = 4'b1111;
                2'b01:   be = addr[1] ? 4'b1100 : 4'b0011;
                default: be = 4'b0001 << addr[1:0];
            endcase
        end
    end

    // Store data copied into every lane it may land in
    always_comb begin
        case (head_fn3[1:0])
            2'b10:   wdata = head_data;
            2'b01:   wdata = {2{head_data[15:0]}};
            default: wdata = {4{head_data[7:0]}};
        endcase
    end

    assign cur_unit = addr[lsu_pkg::BUS_REGION_BIT] ? lsu_pkg::UNIT_BUS : lsu_pkg::UNIT_SCRATCH;

    // Last outstanding load returns this cycle, so the other unit may start
    assign last_return = load_valid & (sub_pending == CNT_W'(1));
    assign unit_stall  = (cur_unit != last_unit) & attr_pending & ~last_return;

    assign issue = head_valid & aligned & scratch_ready & bus_ready & ~unit_stall
                 & (inflight < CNT_W'(OUT_DEPTH));
    assign misaligned = head_valid & ~aligned;

    assign scratch_request = issue & (cur_unit == lsu_pkg::UNIT_SCRATCH);
    assign bus_request     = issue & (cur_unit == lsu_pkg::UNIT_BUS);
    assign rnw             = head_load;
    assign load_issued     = issue & head_load;
    assign load_fn3        = head_fn3;
    assign load_offset     = addr[1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight    <= '0;
            sub_pending <= '0;
            last_unit   <= lsu_pkg::UNIT_SCRATCH;
        end else begin
            // Loads count until the core takes their result
            if (load_issued != wb_accepted) begin
                inflight <= load_issued ? inflight + 1'b1 : inflight - 1'b1;
            end
            if (load_issued != load_valid) begin
                sub_pending <= load_issued ? sub_pending + 1'b1 : sub_pending - 1'b1;
            end
            if (issue) begin
                last_unit <= cur_unit;
            end
        end
    end

endmodule

//--- design/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
    parameter int SCRATCH_WORDS = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_request,
    input  logic [lsu_pkg::XLEN-1:0]   addr,
    input  logic [lsu_pkg::XLEN/8-1:0] be,
    input  logic [lsu_pkg::XLEN-1:0]   wdata,
    input  logic                       rnw,
    output logic                       ready,
    output logic                       rdata_valid,
    output logic [lsu_pkg::XLEN-1:0]   rdata
);

    localparam int XLEN  = lsu_pkg::XLEN;
    localparam int IDX_W = $clog2(SCRATCH_WORDS);

    logic [XLEN-1:0]  mem [SCRATCH_WORDS];
    logic [IDX_W-1:0] idx;
    logic [XLEN-1:0]  rdata_q;

    // Word index, byte offset bits dropped
    assign idx   = addr[IDX_W+1:2];
    assign ready = 1'b1;

    always_ff @(posedge clk) begin
        if (new_request & ~rnw) begin
            for (int i = 0; i < XLEN / 8; i++) begin
                if (be[i]) begin
                    mem[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
        if (new_request & rnw) begin
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= new_request & rnw;
        end
    end

    // Zero when idle so the top level can OR the return buses
    assign rdata = rdata_valid ? rdata_q : '0;

endmodule

//--- design/apb_ls_master.sv
`timescale 1ns/1ps

module apb_ls_master (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_request,
    input  logic [lsu_pkg::XLEN-1:0]   addr,
    input  logic [lsu_pkg::XLEN/8-1:0] be,
    input  logic [lsu_pkg::XLEN-1:0]   wdata,
    input  logic                       rnw,
    output logic                       ready,
    output logic                       rdata_valid,
    output logic [lsu_pkg::XLEN-1:0]   rdata,
    output logic [lsu_pkg::XLEN-1:0]   paddr,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [lsu_pkg::XLEN-1:0]   pwdata,
    output logic [lsu_pkg::XLEN/8-1:0] pstrb,
    input  logic [lsu_pkg::XLEN-1:0]   prdata,
    input  logic                       pready
);

    localparam int XLEN = lsu_pkg::XLEN;

    lsu_pkg::apb_state_t state;
    logic [XLEN-1:0]     addr_q;
    logic [XLEN-1:0]     wdata_q;
    logic [XLEN/8-1:0]   be_q;
    logic                rnw_q;
    logic [XLEN-1:0]     rdata_q;
    logic                start;
    logic                finish;

    assign start  = (state == lsu_pkg::APB_IDLE) & new_request;
    assign finish = (state == lsu_pkg::APB_ACCESS) & pready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= lsu_pkg::APB_IDLE;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= finish & rnw_q;
            case (state)
                lsu_pkg::APB_IDLE:   state <= new_request ? lsu_pkg::APB_SETUP : lsu_pkg::APB_IDLE;
                lsu_pkg::APB_SETUP:  state <= lsu_pkg::APB_ACCESS;
                lsu_pkg::APB_ACCESS: state <= pready ? lsu_pkg::APB_IDLE : lsu_pkg::APB_ACCESS;
                default:             state <= lsu_pkg::APB_IDLE;
            endcase
        end
    end

    // Access fields stay put from SETUP to the end of ACCESS
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            be_q    <= be;
            rnw_q   <= rnw;
        end
        if (finish & rnw_q) begin
            rdata_q <= prdata;
        end
    end

    assign ready   = (state == lsu_pkg::APB_IDLE);
    assign psel    = (state != lsu_pkg::APB_IDLE);
    assign penable = (state == lsu_pkg::APB_ACCESS);
    assign paddr   = addr_q;
    assign pwrite  = ~rnw_q;
    assign pwdata  = wdata_q;
    assign pstrb   = rnw_q ? '0 : be_q;
    assign rdata   = rdata_valid ? rdata_q : '0;

endmodule

//--- design/load_align_writeback.sv
`timescale 1ns/1ps

module load_align_writeback #(
    parameter int OUT_DEPTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     load_issued,
    input  lsu_pkg::ls_size_t        load_fn3,
    input  logic [1:0]               load_offset,
    input  logic                     load_valid,
    input  logic [lsu_pkg::XLEN-1:0] rdata,
    output logic                     attr_pending,
    output logic                     wb_done,
    output logic [lsu_pkg::XLEN-1:0] wb_data,
    input  logic                     wb_accepted
);

    localparam int XLEN = lsu_pkg::XLEN;

    logic [4:0]        attr_head;
    lsu_pkg::ls_size_t head_fn3;
    logic [1:0]        head_offset;
    logic [XLEN-1:0]   shifted;
    logic [XLEN-1:0]   result;

    // Size and byte offset of each load still waiting for its data
    lsu_fifo #(.WIDTH(5), .DEPTH(OUT_DEPTH)) attr_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (load_issued),
        .pop      (load_valid),
        .data_in  ({load_fn3, load_offset}),
        .data_out (attr_head),
        .valid    (attr_pending),
        .full     ()
    );

    assign head_fn3    = lsu_pkg::ls_size_t'(attr_head[4:2]);
    assign head_offset = attr_head[1:0];

    // Addressed byte or halfword moved down to lane 0
    assign shifted = rdata >> {head_offset, 3'b000};

    always_comb begin
        case (head_fn3)
            lsu_pkg::LS_B:  result = {{24{shifted[7]}}, shifted[7:0]};
            lsu_pkg::LS_H:  result = {{16{shifted[15]}}, shifted[15:0]};
            lsu_pkg::LS_BU: result = {24'b0, shifted[7:0]};
            lsu_pkg::LS_HU: result = {16'b0, shifted[15:0]};
            default:        result = shifted;
        endcase
    end

    lsu_fifo #(.WIDTH(XLEN), .DEPTH(OUT_DEPTH)) wb_fifo (
        .clk      (clk),
        .rst      (rst),
        .push     (load_valid),
        .pop      (wb_accepted & wb_done),
        .data_in  (result),
        .data_out (wb_data),
        .valid    (wb_done),
        .full     ()
    );

endmodule

//--- design/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit #(
    parameter int IN_DEPTH      = 4,
    parameter int OUT_DEPTH     = 4,
    parameter int SCRATCH_WORDS = 256
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req_valid,
    output logic                       req_ready,
    input  logic                       req_load,
    input  logic                       req_store,
    input  lsu_pkg::ls_size_t          req_fn3,
    input  logic [lsu_pkg::XLEN-1:0]   req_addr,
    input  logic [lsu_pkg::XLEN-1:0]   req_data,
    output logic                       misaligned,
    output logic                       wb_done,
    output logic [lsu_pkg::XLEN-1:0]   wb_data,
    input  logic                       wb_accepted,
    output logic [lsu_pkg::XLEN-1:0]   paddr,
    output logic                       psel,
    output logic                       penable,
    output logic                       pwrite,
    output logic [lsu_pkg::XLEN-1:0]   pwdata,
    output logic [lsu_pkg::XLEN/8-1:0] pstrb,
    input  logic [lsu_pkg::XLEN-1:0]   prdata,
    input  logic                       pready
);

    localparam int XLEN = lsu_pkg::XLEN;

    logic              scratch_request;
    logic              bus_request;
    logic [XLEN-1:0]   addr;
    logic [XLEN/8-1:0] be;
    logic [XLEN-1:0]   wdata;
    logic              rnw;
    logic              scratch_ready;
    logic              bus_ready;
    logic              scratch_rvalid;
    logic              bus_rvalid;
    logic [XLEN-1:0]   scratch_rdata;
    logic [XLEN-1:0]   bus_rdata;
    logic              load_valid;
    logic [XLEN-1:0]   load_rdata;
    logic              load_issued;
    lsu_pkg::ls_size_t load_fn3;
    logic [1:0]        load_offset;
    logic              attr_pending;

    // Idle sub-units return zero, so an OR merges them
    assign load_valid = scratch_rvalid | bus_rvalid;
    assign load_rdata = scratch_rdata | bus_rdata;

    ls_issue_stage #(.IN_DEPTH(IN_DEPTH), .OUT_DEPTH(OUT_DEPTH)) issue_stage (
        .clk, .rst, .req_valid, .req_ready, .req_load, .req_store, .req_fn3,
        .req_addr, .req_data, .scratch_ready, .bus_ready, .load_valid,
        .wb_accepted, .attr_pending, .scratch_request, .bus_request, .addr, .be,
        .wdata, .rnw, .load_issued, .load_fn3, .load_offset, .misaligned
    );

    scratch_ram #(.SCRATCH_WORDS(SCRATCH_WORDS)) scratch (
        .clk, .rst, .new_request(scratch_request), .addr, .be, .wdata, .rnw,
        .ready(scratch_ready), .rdata_valid(scratch_rvalid), .rdata(scratch_rdata)
    );

    apb_ls_master bus (
        .clk, .rst, .new_request(bus_request), .addr, .be, .wdata, .rnw,
        .ready(bus_ready), .rdata_valid(bus_rvalid), .rdata(bus_rdata),
        .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb, .prdata, .pready
    );

    load_align_writeback #(.OUT_DEPTH(OUT_DEPTH)) writeback (
        .clk, .rst, .load_issued, .load_fn3, .load_offset, .load_valid,
        .rdata(load_rdata), .attr_pending, .wb_done, .wb_data, .wb_accepted
    );

endmodule

//--- test/apb_mem_model.sv
`timescale 1ns/1ps

module apb_mem_model #(
    parameter int WORDS = 16
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    input  logic [3:0]  pstrb,
    output logic [31:0] prdata,
    output logic        pready
);

    localparam int IDX_W = $clog2(WORDS);

    // Shadow storage, also read by the testbench checker
    logic [31:0]      shadow [WORDS];
    logic [IDX_W-1:0] idx;
    int unsigned      waits;

    assign idx    = paddr[IDX_W+1:2];
    assign pready = psel & penable & (waits == 0);
    assign prdata = (psel & penable & ~pwrite) ? shadow[idx] : '0;

    always @(posedge clk) begin
        if (rst) begin
            waits <= 0;
            // Fill pattern tied to the word index
            for (int i = 0; i < WORDS; i++) begin
                shadow[i] <= {16'hc0de, 16'(i)};
            end
        end else if (psel & ~penable) begin
            // 0 to 3 wait states for this transfer
            waits <= $urandom_range(3);
        end else if (psel & penable & ~pready) begin
            waits <= waits - 1;
        end else if (pready & pwrite) begin
            for (int i = 0; i < 4; i++) begin
                if (pstrb[i]) begin
                    shadow[idx][8*i +: 8] <= pwdata[8*i +: 8];
                end
            end
        end
    end

endmodule

//--- test/tb_load_store_unit.sv
`timescale 1ns/1ps

module tb_load_store_unit;

    localparam int N_WORDS  = 16;
    localparam int N_RANDOM = 200;
    // Init stores, directed sizes, misaligned, random, final loads
    localparam int N_REQUESTS  = 2 * N_WORDS + 78 + 24 + N_RANDOM + 2 * N_WORDS;
    localparam int CYCLE_LIMIT = 20 * N_REQUESTS + 200;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    logic              req_load;
    logic              req_store;
    lsu_pkg::ls_size_t req_fn3;
    logic [31:0]       req_addr;
    logic [31:0]       req_data;
    logic              misaligned;
    logic              wb_done;
    logic [31:0]       wb_data;
    logic              wb_accepted;
    logic [31:0]       paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [3:0]        pstrb;
    logic [31:0]       prdata;
    logic              pready;

    logic              random_accept = 1'b0;
    logic              saw_full = 1'b0;
    int                stall_cycles = 0;
    int                mis_seen = 0;
    int                mis_expected = 0;
    int                cycles = 0;
    logic [7:0]        ref_mem [128];
    logic [31:0]       exp_q [$];
    logic [67:0]       apb_q [$];
    logic [67:0]       apb_exp;
    logic [31:0]       wb_expected;

    load_store_unit #(.IN_DEPTH(4), .OUT_DEPTH(4), .SCRATCH_WORDS(256)) dut (
        .clk, .rst, .req_valid, .req_ready, .req_load, .req_store, .req_fn3,
        .req_addr, .req_data, .misaligned, .wb_done, .wb_data, .wb_accepted,
        .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb, .prdata, .pready
    );

    apb_mem_model #(.WORDS(N_WORDS)) apb_mem (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .pstrb, .prdata, .pready
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            stop_on_error($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, expected));
        end
    endtask

    function automatic lsu_pkg::ls_size_t pick_size(input int k);
        case (k)
            0:       return lsu_pkg::LS_B;
            1:       return lsu_pkg::LS_H;
            2:       return lsu_pkg::LS_W;
            3:       return lsu_pkg::LS_BU;
            default: return lsu_pkg::LS_HU;
        endcase
    endfunction

    function automatic int access_bytes(input lsu_pkg::ls_size_t fn3);
        case (fn3[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            default: return 4;
        endcase
    endfunction

    function automatic logic [31:0] region_base(input int r);
        return (r != 0) ? (32'd1 << lsu_pkg::BUS_REGION_BIT) : 32'd0;
    endfunction

    // Region bit plus byte address inside the small test window
    function automatic logic [6:0] ref_index(input logic [31:0] a);
        return {a[lsu_pkg::BUS_REGION_BIT], a[5:0]};
    endfunction

    function automatic logic aligned_ok(input lsu_pkg::ls_size_t fn3, input logic [31:0] a);
        return (a[1:0] & 2'(access_bytes(fn3) - 1)) == 2'b00;
    endfunction

    function automatic logic [3:0] store_strobe(input lsu_pkg::ls_size_t fn3,
                                                input logic [31:0] a);
        return 4'((1 << access_bytes(fn3)) - 1) << a[1:0];
    endfunction

    function automatic logic [31:0] store_lanes(input lsu_pkg::ls_size_t fn3,
                                                input logic [31:0] d);
        case (access_bytes(fn3))
            1:       return {4{d[7:0]}};
            2:       return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    function automatic void store_ref(input lsu_pkg::ls_size_t fn3, input logic [31:0] a,
                                      input logic [31:0] d);
        for (int k = 0; k < access_bytes(fn3); k++) begin
            ref_mem[ref_index(a) + 7'(k)] = d[8*k +: 8];
        end
    endfunction

    // Reference result of a load from the current memory image
    function automatic logic [31:0] expected_load(input lsu_pkg::ls_size_t fn3,
                                                  input logic [31:0] a);
        logic [6:0]  i;
        logic [7:0]  b;
        logic [15:0] h;
        i = ref_index(a);
        b = ref_mem[i];
        h = {ref_mem[i + 7'd1], ref_mem[i]};
        case (fn3)
            lsu_pkg::LS_B:  return {{24{b[7]}}, b};
            lsu_pkg::LS_BU: return {24'h0, b};
            lsu_pkg::LS_H:  return {{16{h[15]}}, h};
            lsu_pkg::LS_HU: return {16'h0, h};
            default:        return {ref_mem[i + 7'd3], ref_mem[i + 7'd2], h};
        endcase
    endfunction

    // Hold the request until the DUT takes it, then update the reference
    task automatic send(input logic load, input lsu_pkg::ls_size_t fn3,
                        input logic [31:0] a, input logic [31:0] d);
        logic taken;
        req_valid = 1'b1;
        req_load  = load;
        req_store = ~load;
        req_fn3   = fn3;
        req_addr  = a;
        req_data  = d;
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        if (!aligned_ok(fn3, a)) begin
            mis_expected++;
        end else if (load) begin
            exp_q.push_back(expected_load(fn3, a));
        end else begin
            store_ref(fn3, a, d);
            if (a[lsu_pkg::BUS_REGION_BIT]) begin
                apb_q.push_back({store_strobe(fn3, a), store_lanes(fn3, d), a});
            end
        end
    endtask

    // Core side takes results only while one is offered
    initial begin
        wb_accepted = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            wb_accepted = wb_done & (random_accept ? ($urandom_range(3) == 0) : 1'b1);
        end
    end

    // Result compare
    always @(negedge clk) begin
        if (!rst && wb_done && wb_accepted) begin
            if (exp_q.size() == 0) begin
                stop_on_error("Writeback result arrived with no load pending");
            end else begin
                wb_expected = exp_q.pop_front();
                check_value("wb_data", wb_data, wb_expected);
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            if (misaligned) begin
                mis_seen++;
            end
            // Request FIFO full while the bus sits idle for two cycles means the load limit holds issue
            if (!req_ready && !psel) begin
                stall_cycles++;
            end else begin
                stall_cycles = 0;
            end
            if (random_accept && stall_cycles >= 2) begin
                saw_full = 1'b1;
            end
            // Completed APB write, check strobes, lane data and address
            if (psel && penable && pready && pwrite) begin
                if (apb_q.size() == 0) begin
                    stop_on_error("APB write seen with no store pending");
                end else begin
                    apb_exp = apb_q.pop_front();
                    check_value("pstrb", pstrb, apb_exp[67:64]);
                    check_value("pwdata", pwdata, apb_exp[63:32]);
                    check_value("paddr", paddr, apb_exp[31:0]);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            stop_on_error($sformatf("Timeout, run exceeded %0d cycles", CYCLE_LIMIT));
        end
    end

    initial begin
        logic [31:0]       a;
        logic              ld;
        lsu_pkg::ls_size_t fn3;
        void'($urandom(32'h573b));
        rst       = 1'b1;
        req_valid = 1'b0;
        req_load  = 1'b0;
        req_store = 1'b0;
        req_fn3   = lsu_pkg::LS_B;
        req_addr  = '0;
        req_data  = '0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("req_ready", req_ready, 1);
        check_value("wb_done", wb_done, 0);
        check_value("psel", psel, 0);
        check_value("misaligned", misaligned, 0);
        @(posedge clk);
        #1;

        // Known word in every location of both regions
        for (int r = 0; r < 2; r++) begin
            for (int w = 0; w < N_WORDS; w++) begin
                send(1'b0, lsu_pkg::LS_W, region_base(r) | 32'(w * 4), $urandom());
            end
        end

        // Every size and aligned offset, then the merged word
        for (int r = 0; r < 2; r++) begin
            for (int s = 0; s < 5; s++) begin
                for (int off = 0; off < 4; off++) begin
                    fn3 = pick_size(s);
                    a   = region_base(r) | 32'((8 + s) * 4 + off);
                    if (aligned_ok(fn3, a)) begin
                        send(1'b0, lsu_pkg::ls_size_t'({1'b0, fn3[1:0]}), a, $urandom());
                        send(1'b1, fn3, a, 32'h0);
                        send(1'b1, lsu_pkg::LS_W, a & ~32'h3, 32'h0);
                    end
                end
            end
        end

        // Misaligned halfwords and words around words 5 and 6
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 5; k++) begin
                for (int l = 0; l < 2; l++) begin
                    fn3 = (k < 2) ? lsu_pkg::LS_H : lsu_pkg::LS_W;
                    a   = region_base(r) | 32'h14 | 32'((k < 2) ? 2 * k + 1 : k - 1);
                    send(l[0], fn3, a, $urandom());
                end
            end
            send(1'b1, lsu_pkg::LS_W, region_base(r) | 32'h14, 32'h0);
            send(1'b1, lsu_pkg::LS_W, region_base(r) | 32'h18, 32'h0);
        end

        // Mixed traffic with writeback back-pressure
        random_accept = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            ld  = ($urandom_range(3) != 0);
            fn3 = pick_size(ld ? $urandom_range(4) : $urandom_range(2));
            a   = region_base($urandom_range(1)) | 32'($urandom_range(15) * 4)
                | 32'($urandom_range(3) & ~(access_bytes(fn3) - 1));
            send(ld, fn3, a, $urandom());
        end
        random_accept = 1'b0;

        for (int r = 0; r < 2; r++) begin
            for (int w = 0; w < N_WORDS; w++) begin
                send(1'b1, lsu_pkg::LS_W, region_base(r) | 32'(w * 4), 32'h0);
            end
        end
        do begin
            @(posedge clk);
        end while (exp_q.size() != 0);

        for (int w = 0; w < N_WORDS; w++) begin
            check_value($sformatf("shadow[%0d]", w), apb_mem.shadow[w],
                        expected_load(lsu_pkg::LS_W, region_base(1) | 32'(w * 4)));
        end
        check_value("misaligned pulses", mis_seen, mis_expected);
        if (!saw_full) begin
            stop_on_error("req_ready never dropped under writeback back-pressure");
        end else if (apb_q.size() != 0) begin
            stop_on_error("APB stores were accepted but never reached the bus");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- tb.f
design/lsu_pkg.sv
design/lsu_fifo.sv
design/ls_issue_stage.sv
design/scratch_ram.sv
design/apb_ls_master.sv
design/load_align_writeback.sv
design/load_store_unit.sv
test/apb_mem_model.sv
test/tb_load_store_unit.sv

//--- run.sh
#!/bin/sh
# Build and run the load/store unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_load_store_unit \
    -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
